// File: vid_consts.svh
`ifndef VID_CONSTS_SVH
`define VID_CONSTS_SVH

//////////////////////////////
// datapath sizes
//////////////////////////////
`define VID_BEAT_W         64
`define VID_BEAT_BYTES     8
`define VID_NUM_VREGS      4
`define VID_BEATS_PER_VREG 8
`define VID_PIPE_DEPTH     6

//////////////////////////////
// apb register offsets
//////////////////////////////
`define VID_REG_CTRL   12'h000
`define VID_REG_CFG    12'h004
`define VID_REG_START  12'h008
`define VID_REG_STATUS 12'h00C
`define VID_WIN_BASE   12'h100

`endif

// File: vid_pkg.sv
`default_nettype none

`include "vid_consts.svh"

package vid_pkg;

    // element width, encoded as log2 of the element size in bytes
    typedef enum logic [1:0] {
        SEW_E8  = 2'd0,
        SEW_E16 = 2'd1,
        SEW_E32 = 2'd2,
        SEW_E64 = 2'd3
    } sew_e;

    // one 64-bit beat, seen as lanes of the current element width
    typedef union packed {
        logic [`VID_BEAT_BYTES-1:0][7:0]     b;  // e8 lanes
        logic [`VID_BEAT_BYTES/2-1:0][15:0]  h;  // e16 lanes
        logic [`VID_BEAT_BYTES/4-1:0][31:0]  w;  // e32 lanes, also the apb halves
        logic [`VID_BEAT_W-1:0]              d;  // e64 lane
    } vec_beat_u;

endpackage

`default_nettype wire

// File: vec_beat_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

interface vec_beat_if;
    import vid_pkg::*;

    logic                       valid;
    logic [1:0]                 vreg;     // destination register
    logic [2:0]                 beat;     // beat within the register
    vec_beat_u                  data;
    logic [`VID_BEAT_BYTES-1:0] byte_en;  // bytes that belong to live elements

    modport src (output valid, vreg, beat, data, byte_en);
    modport snk (input valid, vreg, beat, data, byte_en);

endinterface

`default_nettype wire

// File: apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module apb_regs (
    input  wire                clk,
    input  wire                rst,
    input  wire  [11:0]        paddr,
    input  wire                psel,
    input  wire                penable,
    input  wire                pwrite,
    input  wire  [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               start,
    output vid_pkg::sew_e      sew,
    output logic [6:0]         vl,
    output logic [1:0]         vreg,
    output logic [11:0]        start_idx,
    input  wire                busy,
    input  wire                done,
    output logic [1:0]         rd_vreg,
    output logic [2:0]         rd_beat,
    input  wire vid_pkg::vec_beat_u rd_data
);
    import vid_pkg::*;

    logic access;
    logic wr_en;
    logic reg_hit;
    logic win_hit;

    assign access  = psel && penable;
    assign wr_en   = access && pwrite;
    assign reg_hit = (paddr == `VID_REG_CTRL) || (paddr == `VID_REG_CFG) ||
                     (paddr == `VID_REG_START) || (paddr == `VID_REG_STATUS);
    assign win_hit = (paddr[11:8] == `VID_WIN_BASE >> 8);  // 256 bytes, four registers

    assign pready  = 1'b1;
    assign pslverr = access && !(reg_hit || win_hit);

    assign rd_vreg = paddr[7:6];
    assign rd_beat = paddr[5:3];  // two words per beat

    always_ff @(posedge clk) begin
        if (rst) begin
            start     <= 1'b0;
            sew       <= SEW_E8;
            vl        <= '0;
            vreg      <= '0;
            start_idx <= '0;
        end else begin
            start <= wr_en && (paddr == `VID_REG_CTRL) && pwdata[0] && !busy;
            if (wr_en && (paddr == `VID_REG_CFG)) begin
                sew  <= sew_e'(pwdata[1:0]);
                vreg <= pwdata[5:4];
                vl   <= pwdata[14:8];
            end
            if (wr_en && (paddr == `VID_REG_START)) begin
                start_idx <= pwdata[11:0];
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (win_hit) begin
            prdata = paddr[2] ? rd_data.w[1] : rd_data.w[0];  // even word is the low half
        end else begin
            case (paddr)
                `VID_REG_CFG:    prdata = {17'b0, vl, 2'b0, vreg, 2'b0, sew};
                `VID_REG_START:  prdata = {20'b0, start_idx};
                `VID_REG_STATUS: prdata = {30'b0, done, busy};
                default:         prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: vid_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module vid_ctrl_fsm (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire vid_pkg::sew_e sew,
    input  wire  [6:0]         vl,
    input  wire  [1:0]         vreg,
    input  wire  [11:0]        start_idx,
    output logic               busy,
    output logic               done,
    output logic               cnt_load,
    output logic               cnt_step,
    output logic [3:0]         cnt_beats,
    output logic [11:0]        cnt_start_idx,
    input  wire                cnt_last,
    input  wire  [15:0]        cnt_idx,
    input  wire  [2:0]         cnt_beat,
    input  wire                drain_done,
    output logic               issue,
    output logic [15:0]        issue_idx,
    output vid_pkg::sew_e      issue_sew,
    output logic [6:0]         issue_left,
    output logic [1:0]         issue_vreg,
    output logic [2:0]         issue_beat
);
    import vid_pkg::*;

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] RUN   = 2'd1;
    localparam logic [1:0] DRAIN = 2'd2;

    logic [1:0] state;
    logic       accept;
    logic [6:0] vlmax;
    logic [6:0] vl_eff;
    logic [6:0] beats_full;
    sew_e       sew_q;
    logic [1:0] vreg_q;
    logic [6:0] left_q;

    //////////////////////////////
    // length and beat count
    //////////////////////////////
    assign accept     = start && (state == IDLE);  // go while busy is dropped here
    assign vlmax      = 7'd64 >> sew;
    assign vl_eff     = (vl > vlmax) ? vlmax : vl;
    assign beats_full = (vl_eff + (7'd8 >> sew) - 7'd1) >> (2'd3 - sew);

    assign cnt_load      = accept;
    assign cnt_beats     = beats_full[3:0];
    assign cnt_start_idx = start_idx;
    assign cnt_step      = issue;

    assign busy       = (state != IDLE);
    assign issue      = (state == RUN);
    assign issue_idx  = cnt_idx;
    assign issue_beat = cnt_beat;
    assign issue_sew  = sew_q;
    assign issue_vreg = vreg_q;
    assign issue_left = left_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            case (state)
                IDLE: if (accept) begin
                    done  <= (vl_eff == '0);  // empty vector finishes at once
                    state <= (vl_eff == '0) ? IDLE : RUN;
                end
                RUN: if (cnt_last) begin
                    state <= DRAIN;
                end
                DRAIN: if (drain_done) begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // configuration held for the whole run
    always_ff @(posedge clk) begin
        if (accept) begin
            sew_q  <= sew;
            vreg_q <= vreg;
            left_q <= vl_eff;
        end else if (issue) begin
            left_q <= left_q - (7'd8 >> sew_q);  // elements still to come after this beat
        end
    end

endmodule

`default_nettype wire

// File: elem_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module elem_counter (
    input  wire                clk,
    input  wire                rst,
    input  wire                load,
    input  wire                step,
    input  wire  [3:0]         num_beats,
    input  wire  [11:0]        start_idx,
    input  wire vid_pkg::sew_e sew,
    output logic [2:0]         beat,
    output logic [15:0]        idx,
    output logic               last,
    output logic               drain_done
);

    logic [3:0] nb_q;
    logic       drain_q;
    logic [2:0] tmr_q;

    assign last       = ({1'b0, beat} + 4'd1 == nb_q);
    assign drain_done = drain_q && (tmr_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat    <= '0;
            idx     <= '0;
            nb_q    <= '0;
            drain_q <= 1'b0;
            tmr_q   <= '0;
        end else if (load) begin
            beat    <= '0;
            idx     <= 16'(start_idx);
            nb_q    <= num_beats;
            drain_q <= 1'b0;
        end else begin
            if (step) begin
                beat <= beat + 3'd1;
                idx  <= idx + (16'd8 >> sew);  // one beat worth of elements
                if (last) begin
                    drain_q <= 1'b1;
                    tmr_q   <= 3'(`VID_PIPE_DEPTH - 1);
                end
            end else if (drain_q) begin
                if (tmr_q != '0) tmr_q <= tmr_q - 3'd1;
                else drain_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: vid_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module vid_gen (
    input  wire                clk,
    input  wire                rst,
    input  wire                issue,
    input  wire  [15:0]        idx,
    input  wire vid_pkg::sew_e sew,
    input  wire  [6:0]         left,
    input  wire  [1:0]         vreg,
    input  wire  [2:0]         beat,
    vec_beat_if.src            out
);
    import vid_pkg::*;

    localparam int D = `VID_PIPE_DEPTH;

    vec_beat_u                  fill;
    logic [`VID_BEAT_BYTES-1:0] be;

    vec_beat_u                  data_q [D];
    logic [`VID_BEAT_BYTES-1:0] be_q   [D];
    logic [1:0]                 vreg_q [D];
    logic [2:0]                 beat_q [D];
    logic [D-1:0]               vld_q;

    //////////////////////////////
    // stage 0 lane fill
    //////////////////////////////
    always_comb begin
        fill = '0;
        be   = '0;
        case (sew)
            SEW_E8: for (int l = 0; l < `VID_BEAT_BYTES; l++) begin
                fill.b[l] = 8'(idx + 16'(l));  // wraps at 8 bits
                be[l]     = (7'(l) < left);
            end
            SEW_E16: for (int l = 0; l < `VID_BEAT_BYTES / 2; l++) begin
                fill.h[l]    = idx + 16'(l);
                be[2*l +: 2] = {2{7'(l) < left}};
            end
            SEW_E32: for (int l = 0; l < `VID_BEAT_BYTES / 4; l++) begin
                fill.w[l]    = 32'(idx) + 32'(l);
                be[4*l +: 4] = {4{7'(l) < left}};
            end
            SEW_E64: begin
                fill.d = 64'(idx);
                be     = {`VID_BEAT_BYTES{left != '0}};
            end
        endcase
    end

    //////////////////////////////
    // delay line
    //////////////////////////////
    always_ff @(posedge clk) begin
        data_q[0] <= fill;
        be_q[0]   <= be;
        vreg_q[0] <= vreg;
        beat_q[0] <= beat;
        for (int s = 1; s < D; s++) begin
            data_q[s] <= data_q[s-1];
            be_q[s]   <= be_q[s-1];
            vreg_q[s] <= vreg_q[s-1];
            beat_q[s] <= beat_q[s-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) vld_q <= '0;
        else vld_q <= {vld_q[D-2:0], issue};
    end

    assign out.valid   = vld_q[D-1];
    assign out.data    = data_q[D-1];
    assign out.byte_en = be_q[D-1];
    assign out.vreg    = vreg_q[D-1];
    assign out.beat    = beat_q[D-1];

endmodule

`default_nettype wire

// File: vreg_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module vreg_mem (
    input  wire                clk,
    input  wire                rst,
    vec_beat_if.snk            in,
    input  wire  [1:0]         rd_vreg,
    input  wire  [2:0]         rd_beat,
    output vid_pkg::vec_beat_u rd_data
);
    import vid_pkg::*;

    localparam int ENTRIES = `VID_NUM_VREGS * `VID_BEATS_PER_VREG;

    vec_beat_u  mem [ENTRIES];
    logic [4:0] wr_addr;
    logic [4:0] rd_addr;

    assign wr_addr = {in.vreg, in.beat};
    assign rd_addr = {rd_vreg, rd_beat};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < ENTRIES; a++) begin
                mem[a] <= '0;  // window reads back zero after reset
            end
        end else if (in.valid) begin
            for (int b = 0; b < `VID_BEAT_BYTES; b++) begin
                if (in.byte_en[b]) mem[wr_addr].b[b] <= in.data.b[b];  // tail bytes stay
            end
        end
    end

    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

// File: vid_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module vid_unit_top (
    input  wire         clk,
    input  wire         rst,
    input  wire  [11:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import vid_pkg::*;

    logic        start, busy, done;
    sew_e        sew;
    logic [6:0]  vl;
    logic [1:0]  vreg;
    logic [11:0] start_idx;
    logic [1:0]  rd_vreg;
    logic [2:0]  rd_beat;
    vec_beat_u   rd_data;

    logic        cnt_load, cnt_step, cnt_last, drain_done;
    logic [3:0]  cnt_beats;
    logic [11:0] cnt_start_idx;
    logic [15:0] cnt_idx;
    logic [2:0]  cnt_beat;

    logic        issue;
    logic [15:0] issue_idx;
    sew_e        issue_sew;
    logic [6:0]  issue_left;
    logic [1:0]  issue_vreg;
    logic [2:0]  issue_beat;

    vec_beat_if beat_bus ();

    apb_regs u_regs (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .start, .sew, .vl, .vreg, .start_idx, .busy, .done,
        .rd_vreg, .rd_beat, .rd_data
    );

    vid_ctrl_fsm u_fsm (
        .clk, .rst, .start, .sew, .vl, .vreg, .start_idx, .busy, .done,
        .cnt_load, .cnt_step, .cnt_beats, .cnt_start_idx,
        .cnt_last, .cnt_idx, .cnt_beat, .drain_done,
        .issue, .issue_idx, .issue_sew, .issue_left, .issue_vreg, .issue_beat
    );

    elem_counter u_cnt (
        .clk, .rst, .load(cnt_load), .step(cnt_step), .num_beats(cnt_beats),
        .start_idx(cnt_start_idx), .sew(issue_sew),  // sew only matters while stepping
        .beat(cnt_beat), .idx(cnt_idx), .last(cnt_last), .drain_done
    );

    vid_gen u_gen (
        .clk, .rst, .issue, .idx(issue_idx), .sew(issue_sew), .left(issue_left),
        .vreg(issue_vreg), .beat(issue_beat), .out(beat_bus)
    );

    vreg_mem u_mem (
        .clk, .rst, .in(beat_bus), .rd_vreg, .rd_beat, .rd_data
    );

endmodule

`default_nettype wire

// File: tb_vid_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "vid_consts.svh"

module tb_vid_unit;
    import vid_pkg::*;

    localparam int RUNS           = 40;
    localparam int RUN_CYCLES     = 60;
    localparam int CMP_CYCLES     = 3 * 64;  // one apb read per window word
    localparam int TIMEOUT_CYCLES = 2 * RUNS * (RUN_CYCLES + CMP_CYCLES);

    logic        clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;

    logic [7:0]  shadow [4][64];  // expected store contents byte by byte
    logic [31:0] lcg_state;
    int          cycles;

    vid_unit_top dut (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h exp 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'b0, lcg_state[30:15]};  // low bits of an lcg repeat too soon
    endfunction

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        check_eq("pready", pready, 64'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #4;
        data = prdata;  // sampled halfway between the clock edges
        err  = pslverr;
        check_eq("pready", pready, 64'h1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // applies the vl clamp and element i = start + i and leaves the tail untouched
    function automatic void model_run(input int sew_log, input int vl, input int start,
                                      input int vreg);
        int          bytes;
        int          n;
        logic [63:0] val;
        bytes = 1 << sew_log;
        n     = (vl > 64 / bytes) ? 64 / bytes : vl;
        for (int i = 0; i < n; i++) begin
            val = 64'(start + i);
            for (int k = 0; k < bytes; k++) begin
                shadow[vreg][i * bytes + k] = val[8 * k +: 8];
            end
        end
    endfunction

    task automatic start_vid(input int sew_log, input int vl, input int start, input int vreg);
        apb_write(`VID_REG_CFG, {17'b0, 7'(vl), 2'b0, 2'(vreg), 2'b0, 2'(sew_log)});
        apb_write(`VID_REG_START, {20'b0, 12'(start)});
        apb_write(`VID_REG_CTRL, 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        st = '0;
        while (st[1] == 1'b0) begin
            apb_read(`VID_REG_STATUS, st, err);
        end
        check_eq("status", st, 64'h2);  // done set and busy low
    endtask

    task automatic run_vid(input int sew_log, input int vl, input int start, input int vreg);
        start_vid(sew_log, vl, start, vreg);
        wait_done();
        model_run(sew_log, vl, start, vreg);
    endtask

    task automatic compare_all();
        logic [31:0] got;
        logic [31:0] exp;
        logic        err;
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 16; k++) begin
                apb_read(`VID_WIN_BASE + 12'(r * 64 + k * 4), got, err);
                exp = {shadow[r][4*k+3], shadow[r][4*k+2], shadow[r][4*k+1], shadow[r][4*k]};
                check_eq($sformatf("window v%0d word %0d", r, k), got, exp);
                check_eq("pslverr", err, 64'h0);
            end
        end
    endtask

    // reads a register back beat by beat and checks each element in its own view
    task automatic check_lanes(input int sew_log, input int start, input int vreg, input int vl);
        vec_beat_u   bu;
        logic [31:0] lo;
        logic [31:0] hi;
        logic        err;
        logic [63:0] got;
        logic [63:0] mask;
        int          epb;
        int          n;
        int          e;
        epb  = 8 >> sew_log;
        n    = (vl > 8 * epb) ? 8 * epb : vl;
        mask = (sew_log == 3) ? '1 : (64'd1 << (8 << sew_log)) - 64'd1;
        for (int bt = 0; bt < 8; bt++) begin
            apb_read(`VID_WIN_BASE + 12'(vreg * 64 + bt * 8), lo, err);
            apb_read(`VID_WIN_BASE + 12'(vreg * 64 + bt * 8 + 4), hi, err);
            bu.d = {hi, lo};
            for (int l = 0; l < epb; l++) begin
                e = bt * epb + l;
                if (e < n) begin
                    case (sew_log)
                        0:       got = 64'(bu.b[l]);
                        1:       got = 64'(bu.h[l]);
                        2:       got = 64'(bu.w[l]);
                        default: got = bu.d;
                    endcase
                    check_eq($sformatf("v%0d element %0d", vreg, e), got,
                             64'(start + e) & mask);
                end
            end
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_reset();
        logic [31:0] st;
        logic        err;
        apb_read(`VID_REG_STATUS, st, err);
        check_eq("status", st, 64'h0);
        compare_all();
    endtask

    task automatic test_full_sew();
        for (int s = 0; s < 4; s++) begin
            run_vid(s, 64 >> s, 0, s);
            check_lanes(s, 0, s, 64 >> s);
        end
        compare_all();
    endtask

    task automatic test_tail();
        run_vid(0, 64, 128, 2);  // known pattern under the short run
        run_vid(1, 13, 7, 2);    // last beat holds a single element
        check_lanes(1, 7, 2, 13);
        compare_all();
    endtask

    task automatic test_wrap();
        run_vid(0, 64, 4090, 3);
        check_lanes(0, 4090, 3, 64);
        compare_all();
    endtask

    task automatic test_corners();
        logic [31:0] st;
        logic        err;
        run_vid(2, 0, 99, 0);
        compare_all();
        run_vid(0, 64, 200, 1);
        run_vid(2, 100, 33, 1);
        check_lanes(2, 33, 1, 16);
        compare_all();
        start_vid(0, 64, 10, 2);
        apb_write(`VID_REG_START, 32'd500);
        apb_write(`VID_REG_CTRL, 32'h1);  // lands while the first run is busy
        apb_read(`VID_REG_STATUS, st, err);
        check_eq("status while busy", st, 64'h1);
        wait_done();
        model_run(0, 64, 10, 2);
        compare_all();
        apb_read(12'h010, st, err);
        check_eq("pslverr at 0x010", err, 64'h1);
        apb_read(12'h0FC, st, err);
        check_eq("pslverr at 0x0fc", err, 64'h1);
    endtask

    task automatic test_random();
        int s;
        int vl;
        int start;
        int vreg;
        repeat (20) begin
            s     = lcg_next() % 4;
            vl    = lcg_next() % 128;
            start = lcg_next() % 4096;
            vreg  = lcg_next() % 4;
            run_vid(s, vl, start, vreg);
            compare_all();
        end
    endtask

    initial begin
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        cycles    = 0;
        lcg_state = 32'd73985;
        for (int r = 0; r < 4; r++) begin
            for (int b = 0; b < 64; b++) begin
                shadow[r][b] = 8'h00;
            end
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_full_sew();
        test_tail();
        test_wrap();
        test_corners();
        test_random();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
vid_pkg.sv
vec_beat_if.sv
apb_regs.sv
vid_ctrl_fsm.sv
elem_counter.sv
vid_gen.sv
vreg_mem.sv
vid_unit_top.sv
tb_vid_unit.sv

// File: run.sh
#!/bin/sh
# builds the testbench with verilator, runs it and looks for the pass line
verilator --binary --timing -f src.f --top-module tb_vid_unit -o vsim &&
    ./obj_dir/vsim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
